//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exec
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

# Pass only when the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
+incdir+verif
src/exec_pkg.sv
src/exec_alu.sv
src/exec_cfu.sv
src/exec_wb_reg.sv
src/exec_top.sv
verif/tb_exec.sv

//--- src/exec_alu.sv
// ------------------------------------------------------------------
// Combinational ALU of the execute stage. One adder/subtractor, a
// barrel shifter and the logic ops, picked by a one-hot op. The
// compare flags are always valid for the control-flow unit.
// ------------------------------------------------------------------
`timescale 1ns/1ns

module exec_alu (
    input  exec_pkg::word_t    lhs,         // Left operand
    input  exec_pkg::word_t    rhs,         // Right operand
    input  exec_pkg::alu_op_t  op,          // One-hot operation
    output exec_pkg::word_t    result,      // Selected result
    output exec_pkg::word_t    add_out,     // Raw adder output
    output exec_pkg::cfu_cmp_t cmp          // lhs against rhs
);

    import exec_pkg::*;

    localparam int SHW = $clog2(XLEN);      // Shift amount width

    word_t          rhs_opr;                // Adder right input
    word_t          sum;
    logic [SHW-1:0] shamt;
    word_t          sll_out;
    word_t          srl_out;
    word_t          sra_out;
    logic           cmp_eq;
    logic           cmp_lt;
    logic           cmp_ltu;

    // ------------------------------------------------------------------
    // Adder and compares
    // ------------------------------------------------------------------
    assign rhs_opr = op.sub ? ~rhs : rhs;                   // Invert for sub
    assign sum     = lhs + rhs_opr + word_t'(op.sub);       // Carry-in on sub

    assign cmp_eq  = (lhs == rhs);
    assign cmp_ltu = (lhs < rhs);
    // Signs differ, so the negative one is smaller
    assign cmp_lt  = (lhs[XLEN-1] != rhs[XLEN-1]) ? lhs[XLEN-1] : cmp_ltu;

    // ------------------------------------------------------------------
    // Shifter
    // ------------------------------------------------------------------
    assign shamt   = rhs[SHW-1:0];                          // Low bits only
    assign sll_out = lhs << shamt;
    assign srl_out = lhs >> shamt;
    assign sra_out = word_t'($signed(lhs) >>> shamt);       // Sign fill

    // ------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------
    assign result  = ({XLEN{op.add | op.sub}} & sum)             |
                     ({XLEN{op.band}}         & (lhs & rhs))     |
                     ({XLEN{op.bor}}          & (lhs | rhs))     |
                     ({XLEN{op.bxor}}         & (lhs ^ rhs))     |
                     ({XLEN{op.sll}}          & sll_out)         |
                     ({XLEN{op.srl}}          & srl_out)         |
                     ({XLEN{op.sra}}          & sra_out)         |
                     ({XLEN{op.slt}}          & word_t'(cmp_lt)) |
                     ({XLEN{op.sltu}}         & word_t'(cmp_ltu));

    assign add_out = sum;
    assign cmp     = '{eq: cmp_eq, lt: cmp_lt, ltu: cmp_ltu};

endmodule

//--- src/exec_cfu.sv
// ------------------------------------------------------------------
// Control-flow unit. Resolves branches and jumps from the ALU
// compares, forms the target and requests it from fetch over the
// cf_valid/cf_ack handshake. Raises ecall, ebreak and alignment traps.
// ------------------------------------------------------------------
`timescale 1ns/1ns

module exec_cfu (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  logic               valid,       // Trap-free instruction in stage 2
    input  logic               new_instr,   // Stage 2 handshake this cycle
    input  exec_pkg::word_t    pc,          // Current pc
    input  exec_pkg::word_t    imm,         // Branch or jump offset
    input  exec_pkg::word_t    rs1,         // jalr base
    input  exec_pkg::cfu_op_t  op,
    input  exec_pkg::cfu_cmp_t cmp,         // From the ALU
    input  logic               cf_ack,      // Fetch took the target
    output logic               cf_valid,    // Target request to fetch
    output exec_pkg::word_t    cf_target,
    output logic               trap_raise,
    output logic [6:0]         trap_cause,
    output logic               finished     // Instruction may leave stage 2
);

    import exec_pkg::*;

    logic  br_taken;
    logic  jump;
    logic  taken;
    word_t base;
    word_t sum;
    logic  misalign;
    logic  cf_req;                          // Change pending for this instr
    logic  ack_seen;                        // Fetch already acknowledged

    // ------------------------------------------------------------------
    // Branch decision and target
    // ------------------------------------------------------------------
    assign br_taken = (op.beq  &  cmp.eq ) |
                      (op.bne  & ~cmp.eq ) |
                      (op.blt  &  cmp.lt ) |
                      (op.bge  & ~cmp.lt ) |
                      (op.bltu &  cmp.ltu) |
                      (op.bgeu & ~cmp.ltu);

    assign jump  = op.jal | op.jalr;
    assign taken = br_taken | jump;

    assign base      = op.jalr ? rs1 : pc;                  // jalr is register based
    assign sum       = base + imm;
    assign cf_target = {sum[XLEN-1:1], sum[0] & ~op.jalr};  // jalr drops bit 0

    // ------------------------------------------------------------------
    // Traps
    // ------------------------------------------------------------------
    assign misalign   = taken & cf_target[1];               // Not word aligned
    assign trap_raise = op.ecall | op.ebrk | misalign;
    assign trap_cause = misalign ? TRAP_IALIGN :
                        op.ebrk  ? TRAP_EBREAK :
                                   TRAP_ECALL;

    // ------------------------------------------------------------------
    // Fetch handshake
    // ------------------------------------------------------------------
    assign cf_req   = valid & taken & ~trap_raise;
    assign cf_valid = cf_req & ~ack_seen;                   // Drop once acked
    assign finished = ~cf_req | ack_seen | cf_ack;          // Ack frees stage at once

    always_ff @(posedge g_clk) begin
        if (!g_resetn || new_instr) begin
            ack_seen <= 1'b0;                               // Fresh instruction
        end else if (cf_valid && cf_ack) begin
            ack_seen <= 1'b1;                               // Wait for accept
        end
    end

endmodule

//--- src/exec_pkg.sv
// ------------------------------------------------------------------
// Shared types for the execute stage. Word and register types, the
// ALU and control-flow operation flags, the stage 2 and stage 3
// structs and the trap cause codes. Compile before the RTL modules.
// ------------------------------------------------------------------
package exec_pkg;

    localparam int XLEN = 32;                   // Data path width

    typedef logic [XLEN-1:0] word_t;            // Operand, pc, result
    typedef logic [4:0]      reg_addr_t;        // Register index

    // Trap causes, carried in rd at stage 3
    localparam logic [6:0] TRAP_IALIGN = 7'd0;  // Misaligned jump target
    localparam logic [6:0] TRAP_EBREAK = 7'd3;  // ebreak
    localparam logic [6:0] TRAP_ECALL  = 7'd11; // ecall from M mode

    typedef struct packed {
        logic add;                              // One-hot ALU select
        logic sub;
        logic band;                             // Bitwise and
        logic bor;                              // Bitwise or
        logic bxor;                             // Bitwise xor
        logic sll;
        logic srl;
        logic sra;
        logic slt;
        logic sltu;
    } alu_op_t;

    typedef struct packed {
        logic beq;                              // Conditional branches
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
        logic jal;                              // Unconditional jumps
        logic jalr;
        logic ecall;                            // Environment traps
        logic ebrk;
    } cfu_op_t;

    typedef struct packed {
        logic eq;                               // lhs == rhs
        logic lt;                               // Signed lhs < rhs
        logic ltu;                              // Unsigned lhs < rhs
    } cfu_cmp_t;

    typedef struct packed {
        word_t       pc;                        // Current pc
        word_t       npc;                       // Fall-through pc
        word_t       imm;                       // Decoded immediate
        word_t       alu_lhs;
        word_t       alu_rhs;
        reg_addr_t   rd;
        logic [31:0] instr;                     // Raw instruction word
        logic        trap;                      // Trap flagged by decode
        logic [6:0]  trap_cause;
        alu_op_t     alu_op;
        cfu_op_t     cfu_op;
        logic        wb_alu;                    // Write back ALU result
        logic        wb_npc;                    // Write back npc (link)
    } s2_instr_t;

    typedef struct packed {
        word_t       pc;
        logic [31:0] instr;
        word_t       wdata;                     // Register write data
        reg_addr_t   rd;                        // Trap cause when trap set
        logic        trap;
    } s3_result_t;

endpackage

//--- src/exec_top.sv
// ------------------------------------------------------------------
// Execute stage top level. Takes one decoded instruction from stage 2
// over valid/ready, runs the ALU and control-flow unit on it, and
// hands the result to writeback through the stage 3 register.
// ------------------------------------------------------------------
`timescale 1ns/1ns

module exec_top (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 s2_valid,      // Decode has an instruction
    input  logic                 s2_flush,      // Flush stage 3
    input  exec_pkg::s2_instr_t  s2,
    output logic                 s2_ready,      // Execute can take it
    output logic                 s3_valid,      // Result ready for writeback
    input  logic                 s3_ready,      // Writeback can take it
    output logic                 s3_full,
    output exec_pkg::s3_result_t s3,
    output logic                 cf_valid,      // Control-flow change request
    input  logic                 cf_ack,
    output exec_pkg::word_t      cf_target
);

    import exec_pkg::*;

    word_t      alu_result;
    cfu_cmp_t   alu_cmp;
    logic       cfu_valid;
    logic       cfu_finished;
    logic       cfu_trap;
    logic [6:0] cfu_cause;
    logic       accept;

    // ------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------
    assign cfu_valid = s2_valid & ~s2.trap;         // No jump on decode trap
    assign s2_ready  = s3_ready & cfu_finished;
    assign s3_valid  = s2_valid & cfu_finished;
    assign accept    = s2_valid & s2_ready;         // Same as s3 handshake

    exec_alu u_alu (
        .lhs        (s2.alu_lhs  ),
        .rhs        (s2.alu_rhs  ),
        .op         (s2.alu_op   ),
        .result     (alu_result  ),
        .add_out    (            ),
        .cmp        (alu_cmp     )
    );

    exec_cfu u_cfu (
        .g_clk      (g_clk       ),
        .g_resetn   (g_resetn    ),
        .valid      (cfu_valid   ),
        .new_instr  (accept      ),
        .pc         (s2.pc       ),
        .imm        (s2.imm      ),
        .rs1        (s2.alu_lhs  ),             // rs1 rides on the lhs operand
        .op         (s2.cfu_op   ),
        .cmp        (alu_cmp     ),
        .cf_ack     (cf_ack      ),
        .cf_valid   (cf_valid    ),
        .cf_target  (cf_target   ),
        .trap_raise (cfu_trap    ),
        .trap_cause (cfu_cause   ),
        .finished   (cfu_finished)
    );

    exec_wb_reg u_wb_reg (
        .g_clk      (g_clk       ),
        .g_resetn   (g_resetn    ),
        .flush      (s2_flush    ),
        .accept     (accept      ),
        .instr      (s2          ),
        .alu_result (alu_result  ),
        .cfu_trap   (cfu_trap    ),
        .cfu_cause  (cfu_cause   ),
        .s3         (s3          ),
        .s3_full    (s3_full     )
    );

endmodule

//--- src/exec_wb_reg.sv
// ------------------------------------------------------------------
// Stage 3 result register. Picks the writeback data, merges decode
// and control-flow traps into rd, and loads on each accept. A flush
// empties the stage on the next edge.
// ------------------------------------------------------------------
`timescale 1ns/1ns

module exec_wb_reg (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 flush,         // Discard stage contents
    input  logic                 accept,        // Stage 2 to stage 3 move
    input  exec_pkg::s2_instr_t  instr,         // Instruction leaving stage 2
    input  exec_pkg::word_t      alu_result,
    input  logic                 cfu_trap,      // Trap from the CFU
    input  logic [6:0]           cfu_cause,
    output exec_pkg::s3_result_t s3,
    output logic                 s3_full        // Stage holds an instruction
);

    import exec_pkg::*;

    word_t       n_wdata;
    reg_addr_t   n_rd;
    logic        n_trap;
    word_t       pc_q;
    logic [31:0] instr_q;
    word_t       wdata_q;
    reg_addr_t   rd_q;
    logic        trap_q;

    assign n_wdata = ({XLEN{instr.wb_alu}} & alu_result) |
                     ({XLEN{instr.wb_npc}} & instr.npc);     // Link value

    // Decode trap first, cause code replaces rd
    assign n_trap  = instr.trap | cfu_trap;
    assign n_rd    = instr.trap ? instr.trap_cause[4:0] :
                     cfu_trap   ? cfu_cause[4:0]        :
                                  instr.rd;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush) begin
            s3_full <= 1'b0;
            trap_q  <= 1'b0;
        end else if (accept) begin
            s3_full <= 1'b1;
            trap_q  <= n_trap;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            pc_q    <= instr.pc;
            instr_q <= instr.instr;
            wdata_q <= n_wdata;
            rd_q    <= n_rd;
        end
    end

    assign s3 = '{pc: pc_q, instr: instr_q, wdata: wdata_q, rd: rd_q, trap: trap_q};

endmodule

//--- verif/tb_exec_model.svh
// ----------------------------------------------------------------------
// Reference model and stimulus generator for the execute stage bench.
// Included inside the testbench module body after the rng state.
// ----------------------------------------------------------------------
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

// LCG step, returns the new state
function automatic word_t lcg_next();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng;
endfunction

function automatic word_t expect_alu(s2_instr_t i);
    word_t l;
    word_t r;
    l = i.alu_lhs;
    r = i.alu_rhs;
    if (i.alu_op.add)  return l + r;
    if (i.alu_op.sub)  return l - r;
    if (i.alu_op.band) return l & r;
    if (i.alu_op.bor)  return l | r;
    if (i.alu_op.bxor) return l ^ r;
    if (i.alu_op.sll)  return l << r[4:0];                  // Low 5 bits only
    if (i.alu_op.srl)  return l >> r[4:0];
    if (i.alu_op.sra)  return word_t'($signed(l) >>> r[4:0]);
    if (i.alu_op.slt)  return {31'd0, $signed(l) < $signed(r)};
    if (i.alu_op.sltu) return {31'd0, l < r};
    return '0;
endfunction

function automatic logic expect_taken(s2_instr_t i);
    word_t l;
    word_t r;
    l = i.alu_lhs;
    r = i.alu_rhs;
    return (i.cfu_op.beq  && l == r) || (i.cfu_op.bne  && l != r) ||
           (i.cfu_op.blt  && $signed(l) <  $signed(r)) ||
           (i.cfu_op.bge  && $signed(l) >= $signed(r)) ||
           (i.cfu_op.bltu && l < r) || (i.cfu_op.bgeu && l >= r) ||
           i.cfu_op.jal || i.cfu_op.jalr;
endfunction

function automatic word_t expect_target(s2_instr_t i);
    if (i.cfu_op.jalr) return (i.alu_lhs + i.imm) & ~32'd1;  // rs1 based, bit 0 cleared
    return i.pc + i.imm;
endfunction

// Trap raised in execute, cause through the output argument
function automatic logic expect_cfu_trap(s2_instr_t i, output logic [6:0] cause);
    word_t t;
    t     = expect_target(i);
    cause = TRAP_ECALL;
    if (expect_taken(i) && t[1]) begin
        cause = TRAP_IALIGN;
        return 1'b1;
    end
    if (i.cfu_op.ebrk) cause = TRAP_EBREAK;
    return i.cfu_op.ecall || i.cfu_op.ebrk;
endfunction

function automatic logic expect_cf(s2_instr_t i);
    logic [6:0] c;
    return !i.trap && expect_taken(i) && !expect_cfu_trap(i, c);
endfunction

function automatic s3_result_t expect_s3(s2_instr_t i);
    s3_result_t s;
    logic       ct;
    logic [6:0] c;
    ct      = expect_cfu_trap(i, c);
    s.pc    = i.pc;
    s.instr = i.instr;
    s.wdata = i.wb_alu ? expect_alu(i) : (i.wb_npc ? i.npc : '0);
    s.trap  = i.trap || ct;
    s.rd    = i.trap ? i.trap_cause[4:0] : (ct ? c[4:0] : i.rd);  // Decode trap wins
    return s;
endfunction

// Kind 0 ALU, 1 control flow, 2 trap
function automatic s2_instr_t gen_instr(int kind);
    s2_instr_t i;
    word_t     r;
    i         = '0;
    r         = lcg_next();
    i.pc      = r & ~32'd3;
    i.npc     = i.pc + 32'd4;
    i.instr   = lcg_next();
    i.rd      = i.instr[11:7];
    i.alu_lhs = lcg_next();
    r         = lcg_next();
    i.alu_rhs = (r[15:14] == 2'd0) ? i.alu_lhs : lcg_next();  // Some equal pairs
    r         = lcg_next();
    i.imm     = {{18{r[13]}}, r[13:2], 2'b00};
    if (r[31:30] == 2'd0) i.imm = i.imm | 32'd2;              // Misaligned now and then
    if (kind == 0) begin
        i.alu_op = alu_op_t'(10'b1 << (r % 10));
        i.wb_alu = 1'b1;
    end else if (kind == 1) begin
        i.cfu_op = cfu_op_t'(10'b100 << (r % 8));             // beq through jalr
        i.wb_npc = i.cfu_op.jal | i.cfu_op.jalr;
    end else begin
        case (r % 4)
            0: i.cfu_op.ecall = 1'b1;
            1: i.cfu_op.ebrk  = 1'b1;
            2: begin
                i.trap       = 1'b1;                          // Decode trap
                i.trap_cause = {3'b000, r[19:16]};
                i.cfu_op.jal = r[20];
            end
            default: begin
                i.cfu_op.jal = 1'b1;
                i.imm        = i.imm | 32'd2;                 // Forced misaligned
            end
        endcase
    end
    return i;
endfunction

`endif

//--- verif/tb_exec.sv
// ----------------------------------------------------------------------
// Testbench for the execute stage. Random instructions from an LCG,
// checked against the included model as they retire into stage 3.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_exec;

    import exec_pkg::*;

    localparam int N_TESTS = 6;
    localparam int N_INSTR = 200;
    localparam int TIMEOUT = N_TESTS * N_INSTR * 16 + 800;  // About 16 cycles worst per instr

    logic       g_clk;
    logic       g_resetn;
    logic       s2_valid;
    logic       s2_flush;
    s2_instr_t  s2;
    logic       s2_ready;
    logic       s3_valid;
    logic       s3_ready;
    logic       s3_full;
    s3_result_t s3;
    logic       cf_valid;
    logic       cf_ack;
    word_t      cf_target;

    word_t      rng;                                    // LCG state
    int         errors;
    int         checks;
    int         cycles;
    logic       mon_full;
    logic       mon_acc;
    logic       mon_flush;
    s3_result_t mon_s3;

    `include "tb_exec_model.svh"

    exec_top dut (
        .g_clk     (g_clk    ),
        .g_resetn  (g_resetn ),
        .s2_valid  (s2_valid ),
        .s2_flush  (s2_flush ),
        .s2        (s2       ),
        .s2_ready  (s2_ready ),
        .s3_valid  (s3_valid ),
        .s3_ready  (s3_ready ),
        .s3_full   (s3_full  ),
        .s3        (s3       ),
        .cf_valid  (cf_valid ),
        .cf_ack    (cf_ack   ),
        .cf_target (cf_target)
    );

    always #20 g_clk = ~g_clk;                          // 40 ns period

    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("Run stopped, no finish after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic report_error(string msg);
        errors = errors + 1;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    // Stage 3 must hold while nothing moves in
    always @(negedge g_clk) begin
        if (g_resetn && mon_full && !mon_acc && !mon_flush && s3 != mon_s3)
            report_error("s3 changed with no accept");
        mon_full  <= s3_full;
        mon_acc   <= s2_valid && s2_ready;
        mon_flush <= s2_flush;
        mon_s3    <= s3;
    end

    // ----------------------------------------------------------------------
    // One instruction from drive to retire
    // ----------------------------------------------------------------------
    task automatic run_instr(input s2_instr_t ins, input bit random_ready);
        s3_result_t exp_s3;
        word_t      exp_tgt;
        word_t      r;
        logic       exp_cf;
        logic       exp_fin;
        logic       done;
        logic       saw_cf;
        logic       acked;
        exp_s3  = expect_s3(ins);
        exp_cf  = expect_cf(ins);
        exp_tgt = expect_target(ins);
        done    = 1'b0;
        saw_cf  = 1'b0;
        acked   = 1'b0;
        @(posedge g_clk);
        s2       <= ins;
        s2_valid <= 1'b1;
        while (!done) begin
            @(negedge g_clk);
            exp_fin = !exp_cf || acked || cf_ack;       // Free once fetch acks
            if (cf_valid && !exp_cf) report_error("cf_valid raised for no jump");
            if (cf_valid && cf_target != exp_tgt)
                report_error($sformatf("target %h expected %h", cf_target, exp_tgt));
            if (saw_cf && !acked && !cf_valid) report_error("cf_valid dropped before ack");
            if (s3_valid != exp_fin)
                report_error($sformatf("s3_valid %b expected %b", s3_valid, exp_fin));
            if (s2_ready != (exp_fin && s3_ready))
                report_error($sformatf("s2_ready %b expected %b", s2_ready,
                                       exp_fin && s3_ready));
            saw_cf = saw_cf | cf_valid;
            acked  = acked | (cf_valid & cf_ack);
            done   = s2_ready;
            @(posedge g_clk);
            r = lcg_next();
            cf_ack   <= (r % 3) == 0;                   // Random ack delay
            s3_ready <= random_ready ? r[8] : 1'b1;
            if (done) s2_valid <= 1'b0;
        end
        if (exp_cf && !acked) report_error("jump retired without target request");
        @(negedge g_clk);
        if (!s3_full || s3 != exp_s3)
            report_error($sformatf("s3 %h expected %h", s3, exp_s3));
        checks = checks + 1;
    endtask

    task automatic run_test(string name, int kind, bit random_ready, bit flush);
        int start;
        int k;
        start = errors;
        for (int n = 0; n < N_INSTR; n++) begin
            k = (kind == 3) ? int'(lcg_next() % 3) : kind;  // Kind 3 mixes all
            run_instr(gen_instr(k), random_ready);
            if (flush && n % 2 == 0) begin
                @(posedge g_clk);
                s2_flush <= 1'b1;
                @(posedge g_clk);
                s2_flush <= 1'b0;
                @(negedge g_clk);
                if (s3_full || s3.trap) report_error("flush left stage 3 full");
                checks = checks + 1;
            end
        end
        @(posedge g_clk);
        s3_ready <= 1'b1;
        $display("test %s: %0d instructions, %0d errors", name, N_INSTR, errors - start);
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        g_clk    = 1'b0;
        g_resetn = 1'b0;
        s2_valid = 1'b0;
        s2_flush = 1'b0;
        s2       = '0;
        s3_ready = 1'b1;
        cf_ack   = 1'b0;
        rng      = 32'ha4be;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        repeat (16) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        if (s3_full || s3.trap || s3_valid || cf_valid)
            report_error("outputs high after reset");
        checks = checks + 1;
        $display("test reset: %0d errors", errors);
        run_test("alu", 0, 1'b0, 1'b0);
        run_test("control_flow", 1, 1'b0, 1'b0);
        run_test("traps", 2, 1'b0, 1'b0);
        run_test("back_pressure", 3, 1'b1, 1'b0);
        run_test("flush", 3, 1'b0, 1'b1);
        $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
